// File: source/vend_pkg.sv
package vend_pkg;

    localparam int num_products = 4;

    typedef logic [1:0]                   prod_idx_t;
    typedef logic [2:0]                   item_id_t;
    typedef logic [3:0]                   count_t;
    typedef count_t [num_products-1:0]    stock_array_t;
    typedef logic [7:0]                   money_t;
    typedef logic [7:0]                   lcd_char_t;
    typedef logic [8*16-1:0]              lcd_line_t;
    typedef logic [8*5-1:0]               name_text_t;
    typedef logic [8*2-1:0]               price_text_t;

    ////////////////////////////////////////
    // product tables, index 0 is product 1
    ////////////////////////////////////////
    localparam money_t price_table [num_products] = '{8'd10, 8'd12, 8'd15, 8'd18};
    localparam count_t init_count_table [num_products] = '{4'd9, 4'd1, 4'd0, 4'd4};
    localparam name_text_t name_table [num_products] = '{"Coke ", "Water", "Juice", "Cider"};
    localparam price_text_t price_text_table [num_products] = '{"10", "12", "15", "18"};

    // coin values in 100 won units
    localparam money_t coin_small = 8'd1;
    localparam money_t coin_mid   = 8'd5;
    localparam money_t coin_large = 8'd10;

    // lcd cursor addresses of the marker column
    localparam logic [6:0] ddram_upper = 7'h0d;
    localparam logic [6:0] ddram_lower = 7'h4d;

    ////////////////////////////////////////
    // characters
    ////////////////////////////////////////
    localparam lcd_char_t char_space    = 8'h20;
    localparam lcd_char_t char_star     = 8'h2a;
    localparam lcd_char_t char_dot      = 8'h2e;
    localparam lcd_char_t char_zero     = 8'h30;
    localparam lcd_char_t char_w        = 8'h57;
    localparam lcd_char_t char_sold_out = 8'h58;
    localparam lcd_char_t char_up       = 8'h5e;
    localparam lcd_char_t char_down     = 8'h76;

endpackage

// File: source/menu_status_if.sv
`timescale 1ns/1ns

interface menu_status_if
    import vend_pkg::*;
();

    prod_idx_t    cursor_pos;
    prod_idx_t    window_top;
    item_id_t     selected_item;
    logic         admin_mode;
    stock_array_t stock;

    modport source_cursor (output cursor_pos, output window_top);
    modport source_sale (output selected_item, output admin_mode);
    modport source_stock (output stock);

    // text builder sees the whole machine state
    modport sink (
        input cursor_pos,
        input window_top,
        input selected_item,
        input admin_mode,
        input stock
    );

endinterface

// File: source/stock_cmd_if.sv
`timescale 1ns/1ns

interface stock_cmd_if
    import vend_pkg::*;
();

    // single cycle commands, acted on at the same edge
    logic      vend;
    prod_idx_t vend_idx;
    logic      restock;
    prod_idx_t restock_idx;

    modport controller (
        output vend,
        output vend_idx,
        output restock,
        output restock_idx
    );

    modport executor (input vend, input vend_idx, input restock, input restock_idx);

endinterface

// File: source/menu_cursor.sv
`timescale 1ns/1ns

module menu_cursor
    import vend_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        move_up,
    input  logic                        move_down,
    output logic [6:0]                  ddram_address,
    menu_status_if.source_cursor        status
);

    prod_idx_t cursor_pos;
    prod_idx_t window_top;
    // set when the last accepted move went down
    logic      lower_row;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor_pos <= '0;
            lower_row  <= 1'b0;
        end else if (move_up) begin
            if (cursor_pos != '0) begin
                cursor_pos <= cursor_pos - 1'b1;
                lower_row  <= 1'b0;
            end
        end else if (move_down) begin
            if (cursor_pos != prod_idx_t'(num_products - 1)) begin
                cursor_pos <= cursor_pos + 1'b1;
                lower_row  <= 1'b1;
            end
        end
    end

    // cursor on the lower row means the window starts one above it
    assign window_top = lower_row ? cursor_pos - 1'b1 : cursor_pos;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ddram_address <= ddram_upper;
        end else begin
            ddram_address <= lower_row ? ddram_lower : ddram_upper;
        end
    end

    assign status.cursor_pos = cursor_pos;
    assign status.window_top = window_top;

    // two line window stays inside the product list
    a_window_in_range: assert property (@(posedge clk) disable iff (!rst)
        window_top <= prod_idx_t'(num_products - 2));

endmodule

// File: source/sale_control.sv
`timescale 1ns/1ns

module sale_control
    import vend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    select_toggle,
    input  logic                    buy,
    input  logic                    prod_add,
    input  logic                    admin_toggle,
    input  prod_idx_t               cursor_pos,
    input  money_t                  credit,
    input  stock_array_t            stock,
    stock_cmd_if.controller         cmd,
    menu_status_if.source_sale      status
);

    item_id_t  selected_item;
    logic      admin_mode;
    item_id_t  cursor_item;
    prod_idx_t selected_idx;
    logic      can_vend;

    // product ids start at 1, 0 is no selection
    assign cursor_item  = {1'b0, cursor_pos} + 3'd1;
    assign selected_idx = prod_idx_t'(selected_item - 3'd1);

    assign can_vend = (selected_item != '0)
                      && (stock[selected_idx] != '0)
                      && (credit >= price_table[selected_idx]);

    always_ff @(posedge clk) begin
        if (!rst) begin
            selected_item <= '0;
            admin_mode    <= 1'b0;
        end else begin
            if (select_toggle) begin
                if (selected_item == cursor_item) begin
                    selected_item <= '0;
                end else if (stock[cursor_pos] != '0) begin
                    selected_item <= cursor_item;
                end
            end else if (buy) begin
                // selection ends whether or not the sale went through
                selected_item <= '0;
            end
            if (admin_toggle) begin
                admin_mode <= ~admin_mode;
            end
        end
    end

    ////////////////////////////////////////
    // commands to money and stock
    ////////////////////////////////////////
    assign cmd.vend        = buy & can_vend;
    assign cmd.vend_idx    = selected_idx;
    assign cmd.restock     = prod_add & admin_mode;
    assign cmd.restock_idx = cursor_pos;

    assign status.selected_item = selected_item;
    assign status.admin_mode    = admin_mode;

    // a vend is covered by the credit and the price is taken off on the next edge
    a_vend_paid: assert property (@(posedge clk) disable iff (!rst)
        cmd.vend |-> (credit >= price_table[cmd.vend_idx])
        ##1 (credit == $past(credit - price_table[cmd.vend_idx])));

endmodule

// File: source/credit_unit.sv
`timescale 1ns/1ns

module credit_unit
    import vend_pkg::*;
#(
    parameter int credit_max = 255
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [2:0]          coin_sw,
    input  logic                return_sw,
    output money_t              credit,
    output money_t              display_money_binary,
    stock_cmd_if.executor       cmd
);

    money_t     coin_value;
    logic [8:0] coin_sum;

    // one hot coin pulse, anything else counts as no coin
    always_comb begin
        case (coin_sw)
            3'b100:  coin_value = coin_small;
            3'b010:  coin_value = coin_mid;
            3'b001:  coin_value = coin_large;
            default: coin_value = '0;
        endcase
    end

    assign coin_sum = {1'b0, credit} + {1'b0, coin_value};

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit <= '0;
        end else if (return_sw) begin
            credit <= '0;
        end else if (cmd.vend) begin
            credit <= credit - price_table[cmd.vend_idx];
        end else if (coin_value != '0) begin
            if (coin_sum > credit_max) begin
                credit <= money_t'(credit_max);
            end else begin
                credit <= coin_sum[7:0];
            end
        end
    end

    // money display trails the credit by one edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            display_money_binary <= '0;
        end else begin
            display_money_binary <= credit;
        end
    end

endmodule

// File: source/product_store.sv
`timescale 1ns/1ns

module product_store
    import vend_pkg::*;
#(
    parameter int stock_limit = 9
) (
    input  logic                    clk,
    input  logic                    rst,
    input  prod_idx_t               cursor_pos,
    output stock_array_t            stock,
    output count_t                  prod_count_current,
    stock_cmd_if.executor           cmd,
    menu_status_if.source_stock     status
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_products; i++) begin
                stock[i] <= init_count_table[i];
            end
        end else begin
            for (int i = 0; i < num_products; i++) begin
                if (cmd.vend && cmd.vend_idx == prod_idx_t'(i)) begin
                    stock[i] <= stock[i] - 1'b1;
                end else if (cmd.restock && cmd.restock_idx == prod_idx_t'(i)
                             && stock[i] < stock_limit) begin
                    stock[i] <= stock[i] + 1'b1;
                end
            end
        end
    end

    // count of the item under the cursor for the leds
    always_ff @(posedge clk) begin
        if (!rst) begin
            prod_count_current <= init_count_table[0];
        end else begin
            prod_count_current <= stock[cursor_pos];
        end
    end

    assign status.stock = stock;

    for (genvar i = 0; i < num_products; i++) begin : g_limit_check
        a_count_in_limit: assert property (@(posedge clk) disable iff (!rst)
            stock[i] <= stock_limit);
    end

endmodule

// File: source/lcd_menu_text.sv
`timescale 1ns/1ns

module lcd_menu_text
    import vend_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output lcd_line_t           line1_text,
    output lcd_line_t           line2_text,
    menu_status_if.sink         status
);

    prod_idx_t line1_idx;
    prod_idx_t line2_idx;

    ////////////////////////////////////////
    // one menu line
    ////////////////////////////////////////
    // "n.Name pp00W" then marker, status and scroll arrow
    function automatic lcd_line_t build_line(
        input prod_idx_t idx,
        input item_id_t  selected_item,
        input logic      admin_mode,
        input count_t    count,
        input lcd_char_t arrow
    );
        lcd_char_t number_char;
        lcd_char_t marker;
        lcd_char_t status_char;

        number_char = char_zero + lcd_char_t'(idx) + 8'd1;
        if (selected_item == {1'b0, idx} + 3'd1) begin
            marker = char_star;
        end else begin
            marker = char_space;
        end
        // admin sees the digit, customers only see sold out
        if (admin_mode) begin
            status_char = char_zero + lcd_char_t'(count);
        end else if (count == '0) begin
            status_char = char_sold_out;
        end else begin
            status_char = char_space;
        end
        return {number_char, char_dot, name_table[idx], char_space, price_text_table[idx],
                char_zero, char_zero, char_w, marker, status_char, arrow};
    endfunction

    assign line1_idx = status.window_top;
    assign line2_idx = status.window_top + 2'd1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            line1_text <= build_line(2'd0, '0, 1'b0, init_count_table[0], char_up);
            line2_text <= build_line(2'd1, '0, 1'b0, init_count_table[1], char_down);
        end else begin
            line1_text <= build_line(line1_idx, status.selected_item, status.admin_mode,
                                     status.stock[line1_idx], char_up);
            line2_text <= build_line(line2_idx, status.selected_item, status.admin_mode,
                                     status.stock[line2_idx], char_down);
        end
    end

endmodule

// File: source/vend_top.sv
`timescale 1ns/1ns

module vend_top
    import vend_pkg::*;
#(
    parameter int stock_limit = 9,
    parameter int credit_max  = 255
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] button_sw_oneshot,
    output money_t      display_money_binary,
    output count_t      prod_count_current,
    output lcd_line_t   line1_text,
    output lcd_line_t   line2_text,
    output logic [6:0]  ddram_address
);

    // button positions on the pulse vector
    localparam int btn_coin_large = 0;
    localparam int btn_coin_mid   = 1;
    localparam int btn_coin_small = 2;
    localparam int btn_return     = 3;
    localparam int btn_down       = 4;
    localparam int btn_add        = 5;
    localparam int btn_select     = 7;
    localparam int btn_buy        = 9;
    localparam int btn_up         = 10;
    localparam int btn_admin      = 11;

    logic         move_up, move_down, select_toggle, buy;
    logic         return_sw, prod_add, admin_toggle;
    logic [2:0]   coin_raw, coin_sw;
    logic         busy_move, busy_select, busy_coin, busy_buy, busy_return, busy_add;
    money_t       credit;
    stock_array_t stock;

    ////////////////////////////////////////
    // button priority
    ////////////////////////////////////////
    // each press is dropped when one of higher rank arrives in the same cycle
    assign coin_raw = {button_sw_oneshot[btn_coin_small], button_sw_oneshot[btn_coin_mid],
                       button_sw_oneshot[btn_coin_large]};

    assign busy_move   = button_sw_oneshot[btn_up] | button_sw_oneshot[btn_down];
    assign busy_select = busy_move | button_sw_oneshot[btn_select];
    assign busy_coin   = busy_select | (|coin_raw);
    assign busy_buy    = busy_coin | button_sw_oneshot[btn_buy];
    assign busy_return = busy_buy | button_sw_oneshot[btn_return];
    assign busy_add    = busy_return | button_sw_oneshot[btn_add];

    // up wins over down
    assign move_up       = button_sw_oneshot[btn_up];
    assign move_down     = button_sw_oneshot[btn_down] & ~button_sw_oneshot[btn_up];
    assign select_toggle = button_sw_oneshot[btn_select] & ~busy_move;
    assign coin_sw       = coin_raw & {3{~busy_select}};
    assign buy           = button_sw_oneshot[btn_buy] & ~busy_coin;
    assign return_sw     = button_sw_oneshot[btn_return] & ~busy_buy;
    assign prod_add      = button_sw_oneshot[btn_add] & ~busy_return;
    assign admin_toggle  = button_sw_oneshot[btn_admin] & ~busy_add;

    menu_status_if status_bus ();
    stock_cmd_if   cmd_bus ();

    menu_cursor u_menu_cursor (
        .clk           (clk),
        .rst           (rst),
        .move_up       (move_up),
        .move_down     (move_down),
        .ddram_address (ddram_address),
        .status        (status_bus.source_cursor)
    );

    sale_control u_sale_control (
        .clk           (clk),
        .rst           (rst),
        .select_toggle (select_toggle),
        .buy           (buy),
        .prod_add      (prod_add),
        .admin_toggle  (admin_toggle),
        .cursor_pos    (status_bus.cursor_pos),
        .credit        (credit),
        .stock         (stock),
        .cmd           (cmd_bus.controller),
        .status        (status_bus.source_sale)
    );

    credit_unit #(
        .credit_max (credit_max)
    ) u_credit_unit (
        .clk                  (clk),
        .rst                  (rst),
        .coin_sw              (coin_sw),
        .return_sw            (return_sw),
        .credit               (credit),
        .display_money_binary (display_money_binary),
        .cmd                  (cmd_bus.executor)
    );

    product_store #(
        .stock_limit (stock_limit)
    ) u_product_store (
        .clk                (clk),
        .rst                (rst),
        .cursor_pos         (status_bus.cursor_pos),
        .stock              (stock),
        .prod_count_current (prod_count_current),
        .cmd                (cmd_bus.executor),
        .status             (status_bus.source_stock)
    );

    lcd_menu_text u_lcd_menu_text (
        .clk        (clk),
        .rst        (rst),
        .line1_text (line1_text),
        .line2_text (line2_text),
        .status     (status_bus.sink)
    );

endmodule

// File: tests/vend_tb.sv
`timescale 1ns/1ns

module vend_tb;

    // button pulses, one bit per key
    localparam logic [11:0] b_coin10 = 12'h001;
    localparam logic [11:0] b_coin5  = 12'h002;
    localparam logic [11:0] b_coin1  = 12'h004;
    localparam logic [11:0] b_return = 12'h008;
    localparam logic [11:0] b_down   = 12'h010;
    localparam logic [11:0] b_add    = 12'h020;
    localparam logic [11:0] b_select = 12'h080;
    localparam logic [11:0] b_buy    = 12'h200;
    localparam logic [11:0] b_up     = 12'h400;
    localparam logic [11:0] b_admin  = 12'h800;

    localparam logic [6:0] addr_upper = 7'h0d;
    localparam logic [6:0] addr_lower = 7'h4d;

    // stock holds product n in bits [4n+3:4n]
    typedef struct {
        string       name;
        logic [11:0] buttons;
        logic [7:0]  money;
        logic [3:0]  count;
        logic [6:0]  ddram;
        logic [1:0]  top;
        logic [2:0]  sel;
        logic        admin;
        logic [15:0] stock;
    } row_t;

    logic         clk;
    logic         rst;
    logic [11:0]  buttons;
    logic [7:0]   money_out;
    logic [3:0]   count_out;
    logic [127:0] line1_out;
    logic [127:0] line2_out;
    logic [6:0]   ddram_out;
    row_t         rows[$];
    int           cycles;
    int           cycle_limit;

    vend_top dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (buttons),
        .display_money_binary (money_out),
        .prod_count_current   (count_out),
        .line1_text           (line1_out),
        .line2_text           (line2_out),
        .ddram_address        (ddram_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // timeout
    ////////////////////////////////////////
    initial cycles = 0;
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TESTS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // expected menu line from the 16 character layout
    function automatic logic [127:0] model_line(input logic [1:0] idx, input logic [2:0] sel,
                                                input logic admin, input logic [3:0] count,
                                                input logic [7:0] arrow);
        logic [7:0]  number_char;
        logic [39:0] name;
        logic [15:0] price;
        logic [7:0]  mark;
        logic [7:0]  state_char;

        number_char = "1" + {6'd0, idx};
        case (idx)
            2'd0: begin name = "Coke ";  price = "10"; end
            2'd1: begin name = "Water";  price = "12"; end
            2'd2: begin name = "Juice";  price = "15"; end
            default: begin name = "Cider"; price = "18"; end
        endcase
        mark = (sel == {1'b0, idx} + 3'd1) ? "*" : " ";
        if (admin) begin
            state_char = "0" + {4'd0, count};
        end else if (count == 4'd0) begin
            state_char = "X";
        end else begin
            state_char = " ";
        end
        return {number_char, ".", name, " ", price, "00W", mark, state_char, arrow};
    endfunction

    task automatic add_row(input string name, input logic [11:0] buttons_in,
                           input logic [7:0] money, input logic [3:0] count,
                           input logic [6:0] ddram, input logic [1:0] top,
                           input logic [2:0] sel, input logic admin, input logic [15:0] stock);
        row_t r;
        r = '{name, buttons_in, money, count, ddram, top, sel, admin, stock};
        rows.push_back(r);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////
    task automatic build_table();
        logic [3:0] juice;

        add_row("reset state", 12'h000, 8'd0, 4'd9, addr_upper, 2'd0, 3'd0, 1'b0, 16'h4019);
        add_row("down to water", b_down, 8'd0, 4'd1, addr_lower, 2'd0, 3'd0, 1'b0, 16'h4019);
        add_row("down to juice", b_down, 8'd0, 4'd0, addr_lower, 2'd1, 3'd0, 1'b0, 16'h4019);
        add_row("down to cider", b_down, 8'd0, 4'd4, addr_lower, 2'd2, 3'd0, 1'b0, 16'h4019);
        add_row("down at limit", b_down, 8'd0, 4'd4, addr_lower, 2'd2, 3'd0, 1'b0, 16'h4019);
        add_row("up to juice", b_up, 8'd0, 4'd0, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4019);
        add_row("up to water", b_up, 8'd0, 4'd1, addr_upper, 2'd1, 3'd0, 1'b0, 16'h4019);
        add_row("up to coke", b_up, 8'd0, 4'd9, addr_upper, 2'd0, 3'd0, 1'b0, 16'h4019);
        // purchase of coke
        add_row("coin 10", b_coin10, 8'd10, 4'd9, addr_upper, 2'd0, 3'd0, 1'b0, 16'h4019);
        add_row("coin 5", b_coin5, 8'd15, 4'd9, addr_upper, 2'd0, 3'd0, 1'b0, 16'h4019);
        add_row("select coke", b_select, 8'd15, 4'd9, addr_upper, 2'd0, 3'd1, 1'b0, 16'h4019);
        add_row("buy coke", b_buy, 8'd5, 4'd8, addr_upper, 2'd0, 3'd0, 1'b0, 16'h4018);
        // refusals
        add_row("to water", b_down, 8'd5, 4'd1, addr_lower, 2'd0, 3'd0, 1'b0, 16'h4018);
        add_row("to juice", b_down, 8'd5, 4'd0, addr_lower, 2'd1, 3'd0, 1'b0, 16'h4018);
        add_row("to cider", b_down, 8'd5, 4'd4, addr_lower, 2'd2, 3'd0, 1'b0, 16'h4018);
        add_row("select cider", b_select, 8'd5, 4'd4, addr_lower, 2'd2, 3'd4, 1'b0, 16'h4018);
        add_row("buy cider short", b_buy, 8'd5, 4'd4, addr_lower, 2'd2, 3'd0, 1'b0, 16'h4018);
        add_row("back to juice", b_up, 8'd5, 4'd0, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4018);
        add_row("select sold out", b_select, 8'd5, 4'd0, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4018);
        // restock in admin mode
        add_row("add as customer", b_add, 8'd5, 4'd0, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4018);
        add_row("admin on", b_admin, 8'd5, 4'd0, addr_upper, 2'd2, 3'd0, 1'b1, 16'h4018);
        for (int k = 1; k <= 10; k++) begin
            juice = (k > 9) ? 4'd9 : 4'(k);
            add_row($sformatf("admin add %0d", k), b_add, 8'd5, juice, addr_upper, 2'd2,
                    3'd0, 1'b1, {4'd4, juice, 4'd1, 4'd8});
        end
        add_row("admin off", b_admin, 8'd5, 4'd9, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4918);
        // credit return, coin outranks return
        add_row("coin 1", b_coin1, 8'd6, 4'd9, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4918);
        add_row("coin 10 again", b_coin10, 8'd16, 4'd9, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4918);
        add_row("coin with return", b_coin10 | b_return, 8'd26, 4'd9, addr_upper, 2'd2,
                3'd0, 1'b0, 16'h4918);
        add_row("return", b_return, 8'd0, 4'd9, addr_upper, 2'd2, 3'd0, 1'b0, 16'h4918);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int           gap;
        int           idx1;
        int           idx2;
        row_t         r;
        logic [127:0] exp_line1;
        logic [127:0] exp_line2;

        rst = 1'b0;
        buttons = '0;
        cycle_limit = 0;
        gap = $urandom(32'hef732cfb);
        build_table();
        cycle_limit = 4 + rows.size() * 6 + 20;

        repeat (4) @(posedge clk);
        rst <= 1'b1;

        foreach (rows[n]) begin
            r = rows[n];
            gap = 3 + int'($urandom % 3);
            @(posedge clk);
            buttons <= r.buttons;
            @(posedge clk);
            buttons <= '0;
            repeat (gap - 1) @(posedge clk);
            @(negedge clk);

            idx1 = int'(r.top);
            idx2 = idx1 + 1;
            exp_line1 = model_line(2'(idx1), r.sel, r.admin, r.stock[4*idx1 +: 4], "^");
            exp_line2 = model_line(2'(idx2), r.sel, r.admin, r.stock[4*idx2 +: 4], "v");
            check_value(r.name, "money", 128'(r.money), 128'(money_out));
            check_value(r.name, "count", 128'(r.count), 128'(count_out));
            check_value(r.name, "ddram", 128'(r.ddram), 128'(ddram_out));
            check_value(r.name, "line1", exp_line1, line1_out);
            check_value(r.name, "line2", exp_line2, line2_out);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vending.f
source/vend_pkg.sv
source/menu_status_if.sv
source/stock_cmd_if.sv
source/menu_cursor.sv
source/sale_control.sv
source/credit_unit.sv
source/product_store.sv
source/lcd_menu_text.sv
source/vend_top.sv
tests/vend_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := vend_tb
FILELIST := vending.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
